//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tb_soc_main
FILELIST = filelist.f
OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^sim passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
hdl/soc_pkg.sv
hdl/mem_mapper.sv
hdl/simple_ram.sv
hdl/gpio.sv
hdl/timer.sv
hdl/interrupt_unit.sv
hdl/soc_main.sv
sim/tb_soc_main.sv

//--- hdl/gpio.sv
// gpio block
// led output register, switch and button readback,
// button rising-edge interrupt with enable and clear
`timescale 1ns/10ps

module gpio (
	input logic clk,
	input logic arst_n,
	input logic [soc_pkg::reg_a_w-1:0] a,
	input logic [soc_pkg::data_w-1:0] d,
	input logic we,
	output logic [soc_pkg::data_w-1:0] spo,
	input logic [1:0] btn,
	input logic [1:0] sw,
	output logic [3:0] led,
	output logic irq
);
	import soc_pkg::*;

	logic enable;
	logic pending;
	logic [1:0] btn_q;
	logic btn_rise;
	logic clr_pend;

	assign btn_rise = |(btn & ~btn_q);
	// ctrl bit 1 written as one clears the pending edge
	assign clr_pend = we && (a == gpio_reg_ctrl) && d[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led <= 4'b0;
			enable <= 1'b0;
		end else if (we) begin
			if (a == gpio_reg_led) begin
				led <= d[3:0];
			end
			if (a == gpio_reg_ctrl) begin
				enable <= d[0];
			end
		end
	end

	// edge detector, a new edge beats a clear in the same cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			btn_q <= 2'b0;
			pending <= 1'b0;
		end else begin
			btn_q <= btn;
			if (enable && btn_rise) begin
				pending <= 1'b1;
			end else if (clr_pend) begin
				pending <= 1'b0;
			end
		end
	end

	assign irq = pending;

	// ctrl reads back enable in bit 0, pending in bit 1
	always_comb begin
		case (a)
			gpio_reg_led: spo = {{(data_w-4){1'b0}}, led};
			gpio_reg_in: spo = {{(data_w-4){1'b0}}, btn, sw};
			gpio_reg_ctrl: spo = {{(data_w-2){1'b0}}, pending, enable};
			default: spo = '0;
		endcase
	end

endmodule

//--- hdl/interrupt_unit.sv
// interrupt unit
// 2-bit mask and pending view, cpu external interrupt request
// with timer priority, reply clears the latched gpio edge
`timescale 1ns/10ps

module interrupt_unit (
	input logic clk,
	input logic arst_n,
	input logic [soc_pkg::reg_a_w-1:0] a,
	input logic [soc_pkg::data_w-1:0] d,
	input logic we,
	output logic [soc_pkg::data_w-1:0] spo,
	input logic i_timer,
	input logic i_gpio,
	input logic eip_reply,
	output logic eip,
	output logic eip_istimer
);
	import soc_pkg::*;

	// bit 0 timer, bit 1 gpio
	logic [1:0] mask;
	logic [1:0] pending;
	logic gpio_pend;
	logic i_gpio_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mask <= 2'b0;
		end else if (we && a == int_reg_mask) begin
			mask <= d[1:0];
		end
	end

	// gpio level stays high until software clears it at the gpio,
	// so only its rising edge is latched here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			i_gpio_q <= 1'b0;
			gpio_pend <= 1'b0;
		end else begin
			i_gpio_q <= i_gpio;
			if (i_gpio && !i_gpio_q) begin
				gpio_pend <= 1'b1;
			end else if (eip_reply) begin
				gpio_pend <= 1'b0;
			end
		end
	end

	// timer bit tracks the timer itself
	assign pending = {gpio_pend, i_timer};

	assign eip = |(pending & mask);
	assign eip_istimer = pending[0] & mask[0];

	always_comb begin
		case (a)
			int_reg_mask: spo = {{(data_w-2){1'b0}}, mask};
			int_reg_pending: spo = {{(data_w-2){1'b0}}, pending};
			default: spo = '0;
		endcase
	end

endmodule

//--- hdl/mem_mapper.sv
// physical address decoder for the system bus
// routes one access to ram, gpio, timer or interrupt unit,
// muxes read data and ready back, flags unmapped accesses
`timescale 1ns/10ps

module mem_mapper #(
	parameter int RAM_DEPTH = 10
) (
	input logic [soc_pkg::addr_w-1:0] a,
	input logic [soc_pkg::data_w-1:0] d,
	input logic we,
	input logic rd,
	output logic [soc_pkg::data_w-1:0] spo,
	output logic ready,
	output logic bus_err,

	output logic [RAM_DEPTH-1:0] ram_a,
	output logic [soc_pkg::data_w-1:0] ram_d,
	output logic ram_we,
	output logic ram_rd,
	input logic [soc_pkg::data_w-1:0] ram_spo,
	input logic ram_ready,

	output logic [soc_pkg::reg_a_w-1:0] reg_a,
	output logic [soc_pkg::data_w-1:0] reg_d,
	output logic gpio_we,
	output logic timer_we,
	output logic int_we,
	input logic [soc_pkg::data_w-1:0] gpio_spo,
	input logic [soc_pkg::data_w-1:0] timer_spo,
	input logic [soc_pkg::data_w-1:0] int_spo
);
	import soc_pkg::*;

	logic sel_ram;
	logic sel_gpio;
	logic sel_timer;
	logic sel_int;
	logic access;

	assign access = we | rd;

	// one-hot select from the top nibble
	always_comb begin
		sel_ram = 1'b0;
		sel_gpio = 1'b0;
		sel_timer = 1'b0;
		sel_int = 1'b0;
		case (a[addr_w-1 -: region_w])
			region_ram: sel_ram = 1'b1;
			region_gpio: sel_gpio = 1'b1;
			region_timer: sel_timer = 1'b1;
			region_int: sel_int = 1'b1;
			default: ;
		endcase
	end

	// byte address to word index, bits 1:0 dropped
	assign ram_a = a[RAM_DEPTH+1:2];
	assign ram_d = d;
	assign ram_we = we & sel_ram;
	assign ram_rd = rd & sel_ram;

	assign reg_a = a[reg_a_w+1:2];
	assign reg_d = d;
	assign gpio_we = we & sel_gpio;
	assign timer_we = we & sel_timer;
	assign int_we = we & sel_int;

	// return path
	always_comb begin
		spo = '0;
		ready = 1'b0;
		bus_err = 1'b0;
		if (sel_ram) begin
			spo = ram_spo;
			// ram writes finish at once, reads wait for the ram
			ready = we | ram_ready;
		end else if (sel_gpio) begin
			spo = gpio_spo;
			ready = access;
		end else if (sel_timer) begin
			spo = timer_spo;
			ready = access;
		end else if (sel_int) begin
			spo = int_spo;
			ready = access;
		end else begin
			// unmapped: answer with zero and flag it
			ready = access;
			bus_err = access;
		end
	end

endmodule

//--- hdl/simple_ram.sv
// single-port word RAM
// write on the clock, registered read with a one-cycle ready pulse
`timescale 1ns/10ps

module simple_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 10
) (
	input logic clk,
	input logic arst_n,
	input logic [DEPTH-1:0] a,
	input logic [WIDTH-1:0] d,
	input logic we,
	input logic rd,
	output logic [WIDTH-1:0] spo,
	output logic ready
);

	logic [WIDTH-1:0] mem [0:(1<<DEPTH)-1];

	// start from a zeroed array
	initial begin
		for (int i = 0; i < (1 << DEPTH); i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[a] <= d;
		end
		if (rd) begin
			spo <= mem[a];
		end
	end

	// rd is held until ready, so skip the cycle that
	// completes the access to avoid a second pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ready <= 1'b0;
		end else begin
			ready <= rd & ~ready;
		end
	end

endmodule

//--- hdl/soc_main.sv
// subsystem top level
// memory mapper, data ram, gpio, timer and interrupt unit
// on one bus driven by an external master
`timescale 1ns/10ps

module soc_main #(
	parameter logic [soc_pkg::data_w-1:0] TIMER_COUNTER = 1000000,
	parameter int RAM_DEPTH = 10
) (
	input logic clk,
	input logic arst_n,
	input logic [soc_pkg::addr_w-1:0] a,
	input logic [soc_pkg::data_w-1:0] d,
	input logic we,
	input logic rd,
	output logic [soc_pkg::data_w-1:0] spo,
	output logic ready,
	output logic bus_err,
	output logic eip,
	output logic eip_istimer,
	input logic eip_reply,
	input logic [1:0] btn,
	input logic [1:0] sw,
	output logic [3:0] led
);
	import soc_pkg::*;

	// ram side
	logic [RAM_DEPTH-1:0] ram_a;
	logic [data_w-1:0] ram_d;
	logic ram_we;
	logic ram_rd;
	logic [data_w-1:0] ram_spo;
	logic ram_ready;

	// shared register bus
	logic [reg_a_w-1:0] reg_a;
	logic [data_w-1:0] reg_d;
	logic gpio_we;
	logic timer_we;
	logic int_we;
	logic [data_w-1:0] gpio_spo;
	logic [data_w-1:0] timer_spo;
	logic [data_w-1:0] int_spo;

	// interrupt sources
	logic irq_gpio;
	logic irq_timer;

	mem_mapper #(
		.RAM_DEPTH(RAM_DEPTH)
	) mem_mapper_inst (
		.a(a),
		.d(d),
		.we(we),
		.rd(rd),
		.spo(spo),
		.ready(ready),
		.bus_err(bus_err),
		.ram_a(ram_a),
		.ram_d(ram_d),
		.ram_we(ram_we),
		.ram_rd(ram_rd),
		.ram_spo(ram_spo),
		.ram_ready(ram_ready),
		.reg_a(reg_a),
		.reg_d(reg_d),
		.gpio_we(gpio_we),
		.timer_we(timer_we),
		.int_we(int_we),
		.gpio_spo(gpio_spo),
		.timer_spo(timer_spo),
		.int_spo(int_spo)
	);

	simple_ram #(
		.WIDTH(data_w),
		.DEPTH(RAM_DEPTH)
	) ram_inst (
		.clk(clk),
		.arst_n(arst_n),
		.a(ram_a),
		.d(ram_d),
		.we(ram_we),
		.rd(ram_rd),
		.spo(ram_spo),
		.ready(ram_ready)
	);

	gpio gpio_inst (
		.clk(clk),
		.arst_n(arst_n),
		.a(reg_a),
		.d(reg_d),
		.we(gpio_we),
		.spo(gpio_spo),
		.btn(btn),
		.sw(sw),
		.led(led),
		.irq(irq_gpio)
	);

	timer #(
		.TIMER_COUNTER(TIMER_COUNTER)
	) timer_inst (
		.clk(clk),
		.arst_n(arst_n),
		.a(reg_a),
		.d(reg_d),
		.we(timer_we),
		.spo(timer_spo),
		.irq(irq_timer)
	);

	interrupt_unit interrupt_unit_inst (
		.clk(clk),
		.arst_n(arst_n),
		.a(reg_a),
		.d(reg_d),
		.we(int_we),
		.spo(int_spo),
		.i_timer(irq_timer),
		.i_gpio(irq_gpio),
		.eip_reply(eip_reply),
		.eip(eip),
		.eip_istimer(eip_istimer)
	);

endmodule

//--- hdl/soc_pkg.sv
// shared constants for the bus-side subsystem
// bus widths, address map regions and per-peripheral register offsets

package soc_pkg;

	// bus widths
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// address bits 31:28 select the target
	localparam int region_w = 4;
	localparam logic [region_w-1:0] region_ram = 4'h0;
	localparam logic [region_w-1:0] region_gpio = 4'h9;
	localparam logic [region_w-1:0] region_timer = 4'ha;
	localparam logic [region_w-1:0] region_int = 4'hb;

	// word index inside a peripheral
	localparam int reg_a_w = 3;

	// gpio registers
	localparam logic [reg_a_w-1:0] gpio_reg_led = 3'd0;
	localparam logic [reg_a_w-1:0] gpio_reg_in = 3'd1;
	localparam logic [reg_a_w-1:0] gpio_reg_ctrl = 3'd2;

	// timer registers
	localparam logic [reg_a_w-1:0] timer_reg_ctrl = 3'd0;
	localparam logic [reg_a_w-1:0] timer_reg_period = 3'd1;
	localparam logic [reg_a_w-1:0] timer_reg_count = 3'd2;

	// interrupt unit registers
	localparam logic [reg_a_w-1:0] int_reg_mask = 3'd0;
	localparam logic [reg_a_w-1:0] int_reg_pending = 3'd1;

endpackage

//--- hdl/timer.sv
// periodic timer
// counts 0 to period-1 while enabled, sets pending at each wrap
// ctrl: bit 0 enable, bit 1 write one to clear pending
`timescale 1ns/10ps

module timer #(
	parameter logic [soc_pkg::data_w-1:0] TIMER_COUNTER = 1000000
) (
	input logic clk,
	input logic arst_n,
	input logic [soc_pkg::reg_a_w-1:0] a,
	input logic [soc_pkg::data_w-1:0] d,
	input logic we,
	output logic [soc_pkg::data_w-1:0] spo,
	output logic irq
);
	import soc_pkg::*;

	logic enable;
	logic pending;
	logic [data_w-1:0] period;
	logic [data_w-1:0] count;
	logic wrap;
	logic clr_pend;

	// >= keeps a shrunk period from running the full 32-bit range
	assign wrap = enable && (count >= period - 1'b1);
	assign clr_pend = we && (a == timer_reg_ctrl) && d[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enable <= 1'b0;
			period <= TIMER_COUNTER;
		end else if (we) begin
			if (a == timer_reg_ctrl) begin
				enable <= d[0];
			end
			if (a == timer_reg_period) begin
				period <= d;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			pending <= 1'b0;
		end else begin
			if (!enable || wrap) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
			// period end wins over a clear in the same cycle
			if (wrap) begin
				pending <= 1'b1;
			end else if (clr_pend) begin
				pending <= 1'b0;
			end
		end
	end

	assign irq = pending;

	always_comb begin
		case (a)
			timer_reg_ctrl: spo = {{(data_w-2){1'b0}}, pending, enable};
			timer_reg_period: spo = period;
			timer_reg_count: spo = count;
			default: spo = '0;
		endcase
	end

endmodule

//--- sim/tb_soc_main.sv
// testbench for soc_main
// bus master that runs a table of accesses, button changes and replies,
// checks read data, ready latency, bus error and interrupt lines
`timescale 1ns/10ps

module tb_soc_main;
	import soc_pkg::*;

	localparam int timer_counter = 40;
	localparam int ram_depth = 10;
	localparam int timer_period = 10;
	// about 50 entries times one 40-cycle timer period
	localparam int max_cycles = 2000;
	localparam int wait_limit = 50;
	localparam int table_size = 64;

	// table operations
	localparam int op_wr = 0;
	localparam int op_rd = 1;
	localparam int op_rd_below = 2;
	localparam int op_btn = 3;
	localparam int op_reply = 4;
	localparam int op_wait = 5;
	localparam int op_led = 6;

	logic clk;
	logic arst_n;
	logic [addr_w-1:0] a;
	logic [data_w-1:0] d;
	logic we;
	logic rd;
	logic [data_w-1:0] spo;
	logic ready;
	logic bus_err;
	logic eip;
	logic eip_istimer;
	logic eip_reply;
	logic [1:0] btn;
	logic [1:0] sw;
	logic [3:0] led;

	int t_op [table_size];
	logic [31:0] t_addr [table_size];
	logic [31:0] t_data [table_size];
	logic [31:0] t_spo [table_size];
	logic t_eip [table_size];
	logic t_ist [table_size];
	logic t_err [table_size];
	int n_entries;
	int errors;
	int cycles;

	soc_main #(
		.TIMER_COUNTER(timer_counter),
		.RAM_DEPTH(ram_depth)
	) i_soc_main (
		.clk(clk),
		.arst_n(arst_n),
		.a(a),
		.d(d),
		.we(we),
		.rd(rd),
		.spo(spo),
		.ready(ready),
		.bus_err(bus_err),
		.eip(eip),
		.eip_istimer(eip_istimer),
		.eip_reply(eip_reply),
		.btn(btn),
		.sw(sw),
		.led(led)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("sim failed");
			$finish;
		end
	end

	task automatic add_entry(input int op, input logic [31:0] addr, input logic [31:0] data,
			input logic [31:0] exp_spo, input logic exp_eip, input logic exp_ist,
			input logic exp_err);
		t_op[n_entries] = op;
		t_addr[n_entries] = addr;
		t_data[n_entries] = data;
		t_spo[n_entries] = exp_spo;
		t_eip[n_entries] = exp_eip;
		t_ist[n_entries] = exp_ist;
		t_err[n_entries] = exp_err;
		n_entries++;
	endtask

	task automatic compare_value(input int idx, input string name, input logic [31:0] exp_v,
			input logic [31:0] got_v);
		if (got_v !== exp_v) begin
			errors++;
			$display("FAILED entry %0d: %s expected %h got %h", idx, name, exp_v, got_v);
		end
	endtask

	// drive on the falling edge and sample in the low phase until ready
	task automatic bus_access(input logic is_wr, input logic [31:0] addr,
			input logic [31:0] data, output logic [31:0] rdata, output logic err,
			output int lat);
		@(negedge clk);
		a = addr;
		d = data;
		we = is_wr;
		rd = !is_wr;
		lat = 0;
		#5;
		while (!ready && lat < wait_limit) begin
			@(negedge clk);
			#5;
			lat++;
		end
		if (!ready) begin
			errors++;
			$display("no ready for access to %h within %0d cycles", addr, wait_limit);
		end
		rdata = spo;
		err = bus_err;
		@(negedge clk);
		we = 1'b0;
		rd = 1'b0;
		#5;
	endtask

	task automatic wait_irq(input int idx, input logic exp_eip, input logic exp_ist,
			input int limit);
		int n;
		n = 0;
		while ((eip !== exp_eip || eip_istimer !== exp_ist) && n < limit) begin
			@(negedge clk);
			#5;
			n++;
		end
		if (eip !== exp_eip || eip_istimer !== exp_ist) begin
			errors++;
			$display("entry %0d: interrupt lines not in the expected state within %0d cycles",
				idx, limit);
		end
	endtask

	task automatic build_table();
		logic [31:0] wa [8];
		logic [31:0] wd [8];
		int k;
		// one random word address in each 128-word block
		for (k = 0; k < 8; k++) begin
			wa[k] = k * 128 + ($urandom % 128);
			wd[k] = $urandom;
			add_entry(op_wr, wa[k] << 2, wd[k], 0, 0, 0, 0);
		end
		for (k = 0; k < 8; k++) begin
			add_entry(op_rd, wa[k] << 2, 0, wd[k], 0, 0, 0);
		end
		// gpio led and inputs with the edge interrupt disabled
		add_entry(op_wr, 32'h9000_0000, 32'ha, 0, 0, 0, 0);
		add_entry(op_led, 0, 32'ha, 0, 0, 0, 0);
		add_entry(op_rd, 32'h9000_0000, 0, 32'ha, 0, 0, 0);
		add_entry(op_btn, 0, 32'h9, 0, 0, 0, 0);
		add_entry(op_rd, 32'h9000_0004, 0, 32'h9, 0, 0, 0);
		add_entry(op_btn, 0, 32'h0, 0, 0, 0, 0);
		add_entry(op_rd, 32'h9000_0008, 0, 32'h0, 0, 0, 0);
		// unmapped region leaves ram and led alone
		add_entry(op_wr, 32'h5000_0000, 32'hffff_ffff, 0, 0, 0, 1);
		add_entry(op_rd, 32'h5000_0000, 0, 32'h0, 0, 0, 1);
		add_entry(op_rd, 32'h9000_0000, 0, 32'ha, 0, 0, 0);
		add_entry(op_rd, wa[0] << 2, 0, wd[0], 0, 0, 0);
		// gpio interrupt, reply and clear
		add_entry(op_wr, 32'hb000_0000, 32'h2, 0, 0, 0, 0);
		add_entry(op_wr, 32'h9000_0008, 32'h1, 0, 0, 0, 0);
		add_entry(op_btn, 0, 32'h4, 0, 1, 0, 0);
		add_entry(op_rd, 32'hb000_0004, 0, 32'h2, 1, 0, 0);
		add_entry(op_reply, 0, 0, 0, 0, 0, 0);
		add_entry(op_rd, 32'h9000_0008, 0, 32'h3, 0, 0, 0);
		add_entry(op_wr, 32'h9000_0008, 32'h3, 0, 0, 0, 0);
		add_entry(op_rd, 32'h9000_0008, 0, 32'h1, 0, 0, 0);
		add_entry(op_btn, 0, 32'h0, 0, 0, 0, 0);
		// timer with a short period, request due within one period
		add_entry(op_rd, 32'ha000_0004, 0, timer_counter, 0, 0, 0);
		add_entry(op_wr, 32'hb000_0000, 32'h1, 0, 0, 0, 0);
		add_entry(op_wr, 32'ha000_0004, timer_period, 0, 0, 0, 0);
		add_entry(op_wr, 32'ha000_0000, 32'h1, 0, 0, 0, 0);
		add_entry(op_wait, 0, timer_period, 0, 1, 1, 0);
		add_entry(op_rd_below, 32'ha000_0008, 0, timer_period, 1, 1, 0);
		add_entry(op_wr, 32'ha000_0000, 32'h3, 0, 0, 0, 0);
		add_entry(op_wr, 32'ha000_0000, 32'h2, 0, 0, 0, 0);
		// both sources pending with timer priority
		add_entry(op_wr, 32'hb000_0000, 32'h3, 0, 0, 0, 0);
		add_entry(op_btn, 0, 32'h4, 0, 1, 0, 0);
		add_entry(op_wr, 32'ha000_0000, 32'h1, 0, 1, 0, 0);
		add_entry(op_wait, 0, timer_period, 0, 1, 1, 0);
		add_entry(op_rd, 32'hb000_0004, 0, 32'h3, 1, 1, 0);
		add_entry(op_wr, 32'hb000_0000, 32'h2, 0, 1, 0, 0);
		add_entry(op_rd, 32'hb000_0004, 0, 32'h3, 1, 0, 0);
		add_entry(op_reply, 0, 0, 0, 0, 0, 0);
	endtask

	task automatic run_entry(input int i);
		logic [31:0] rdata;
		logic err;
		int lat;
		int exp_lat;
		case (t_op[i])
			op_wr, op_rd, op_rd_below: begin
				bus_access(t_op[i] == op_wr, t_addr[i], t_data[i], rdata, err, lat);
				// only ram reads take a cycle
				exp_lat = (t_op[i] != op_wr && t_addr[i][31:28] == region_ram) ? 1 : 0;
				if (lat != exp_lat) begin
					errors++;
					$display("FAILED entry %0d: ready latency expected %h got %h", i,
						exp_lat, lat);
				end
				compare_value(i, "bus_err", t_err[i], err);
				if (t_op[i] == op_rd) begin
					compare_value(i, "spo", t_spo[i], rdata);
				end
				if (t_op[i] == op_rd_below && rdata >= t_spo[i]) begin
					errors++;
					$display("FAILED entry %0d: spo expected below %h got %h", i,
						t_spo[i], rdata);
				end
			end
			op_btn: begin
				@(negedge clk);
				btn = t_data[i][3:2];
				sw = t_data[i][1:0];
				#5;
				wait_irq(i, t_eip[i], t_ist[i], wait_limit);
			end
			op_reply: begin
				@(negedge clk);
				eip_reply = 1'b1;
				@(negedge clk);
				eip_reply = 1'b0;
				#5;
			end
			op_wait: wait_irq(i, t_eip[i], t_ist[i], t_data[i]);
			op_led: compare_value(i, "led", t_data[i], {28'b0, led});
			default: ;
		endcase
		compare_value(i, "eip", t_eip[i], eip);
		compare_value(i, "eip_istimer", t_ist[i], eip_istimer);
	endtask

	initial begin
		int i;
		void'($urandom(44493));
		arst_n = 1'b0;
		a = '0;
		d = '0;
		we = 1'b0;
		rd = 1'b0;
		eip_reply = 1'b0;
		btn = 2'b0;
		sw = 2'b0;
		errors = 0;
		cycles = 0;
		n_entries = 0;
		build_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		#5;
		for (i = 0; i < n_entries; i++) begin
			run_entry(i);
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
